/* tb.f */
+incdir+design
design/intra4_pkg.sv
design/intra4_predict.sv
design/intra4_sse.sv
design/intra4_best.sv
design/intra4_top.sv
testbench/tb_intra4.sv

/* Bender.yml */
package:
  name: intra4

sources:
  - include_dirs:
      - design
    files:
      - design/intra4_pkg.sv
      - design/intra4_predict.sv
      - design/intra4_sse.sv
      - design/intra4_best.sv
      - design/intra4_top.sv
      - target: simulation
        files:
          - testbench/tb_intra4.sv

/* testbench/tb_intra4.sv */
/*
 * Testbench for the 4x4 intra mode picker
 * Directed and random blocks checked against a reference model
 */

`default_nettype none

`include "intra4_defs.svh"

module tb_intra4;

    import intra4_pkg::*;

    localparam int NUM_RESULTS    = 306;
    localparam int TIMEOUT_CYCLES = 12 * (NUM_RESULTS + 2) + 100;

    typedef struct packed {
        mode_t      mode;
        score_t     score;
        pix_block_t pred;
        int         due;
    } result_t;

    logic       clk;
    logic       rst_n;
    logic       start_i;
    pix_block_t src_i;
    pix_t       top_left_i;
    row_t       top_i;
    row_t       left_i;
    lambda_t    lambda_i;
    logic       done_o;
    mode_t      best_mode_o;
    score_t     best_score_o;
    pix_block_t best_pred_o;

    result_t    exp_q[$];
    result_t    acc_res;
    result_t    cmp_res;
    mode_t      last_mode;
    score_t     last_score;
    pix_block_t last_pred;
    int         cycles;
    int         free_at;
    int         checked;
    int         mismatches;
    int         protocol_errs;
    integer     seed;

    intra4_top intra4_top_i (.*);

    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic pix_block_t predict_block(input mode_t m, input pix_t tl,
                                                 input row_t top, input row_t left);
        pix_block_t b;
        int         dc;
        int         v;
        dc = 4;
        for (int i = 0; i < 4; i++)
            dc = dc + int'(top[i]) + int'(left[i]);
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                case (m)
                    MODE_DC: v = dc / 8;
                    MODE_TM: v = int'(top[x]) + int'(left[y]) - int'(tl);
                    MODE_VE: v = top[x];
                    default: v = left[y];
                endcase
                // Only TM can leave the pixel range
                b.pix[y * 4 + x] = pix_t'((v < 0) ? 0 : ((v > 255) ? 255 : v));
            end
        end
        return b;
    endfunction

    function automatic int cost_of(input mode_t m);
        case (m)
            MODE_DC: return `INTRA4_COST_DC;
            MODE_TM: return `INTRA4_COST_TM;
            MODE_VE: return `INTRA4_COST_VE;
            default: return `INTRA4_COST_HE;
        endcase
    endfunction

    function automatic result_t pick_mode(input pix_block_t src, input pix_t tl,
                                          input row_t top, input row_t left,
                                          input lambda_t lambda);
        result_t    r;
        pix_block_t p;
        longint     sse;
        longint     sc;
        longint     best;
        int         d;
        best = 0;
        for (int m = 0; m < `INTRA4_NUM_MODES; m++) begin
            p = predict_block(mode_t'(m), tl, top, left);
            sse = 0;
            for (int i = 0; i < 16; i++) begin
                d = int'(src.pix[i]) - int'(p.pix[i]);
                sse = sse + d * d;
            end
            sc = 256 * sse + longint'(lambda) * cost_of(mode_t'(m));
            // Ties keep the lower mode code
            if (m == 0 || sc < best) begin
                best    = sc;
                r.mode  = mode_t'(m);
                r.score = score_t'(sc);
                r.pred  = p;
            end
        end
        r.due = 0;
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks and stimulus
    // ------------------------------------------------------------------------
    task automatic check_mode(input string name, input mode_t expected, input mode_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s at cycle %0d: expected %h, actual %h",
                     name, cycles, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_score(input string name, input score_t expected, input score_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s at cycle %0d: expected %h, actual %h",
                     name, cycles, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_block(input string name, input pix_block_t expected,
                               input pix_block_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s at cycle %0d: expected %h, actual %h",
                     name, cycles, expected, actual);
            mismatches++;
        end
    endtask

    task automatic drive_block(input pix_block_t src, input pix_t tl, input row_t top,
                               input row_t left, input lambda_t lambda);
        @(negedge clk);
        src_i      = src;
        top_left_i = tl;
        top_i      = top;
        left_i     = left;
        lambda_i   = lambda;
        start_i    = 1'b1;
        @(negedge clk);
        start_i    = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic expect_best(input mode_t want);
        wait_idle();
        check_mode("best_mode_o directed", want, best_mode_o);
    endtask

    // ------------------------------------------------------------------------
    // Start tracking, result compare and timeout
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (rst_n && start_i && cycles >= free_at) begin
            acc_res     = pick_mode(src_i, top_left_i, top_i, left_i, lambda_i);
            acc_res.due = cycles + 6;
            exp_q.push_back(acc_res);
            free_at = cycles + 5;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (exp_q.size() != 0 && exp_q[0].due < cycles) begin
                $display("Error: no done_o for the block due at cycle %0d", exp_q[0].due);
                protocol_errs++;
                cmp_res = exp_q.pop_front();
            end
            if (done_o) begin
                if (exp_q.size() == 0) begin
                    $display("Error: done_o high at cycle %0d with no block in flight", cycles);
                    protocol_errs++;
                end else begin
                    cmp_res = exp_q.pop_front();
                    if (cmp_res.due != cycles) begin
                        $display("Error: done_o at cycle %0d, expected at cycle %0d",
                                 cycles, cmp_res.due);
                        protocol_errs++;
                    end
                    check_mode("best_mode_o", cmp_res.mode, best_mode_o);
                    check_score("best_score_o", cmp_res.score, best_score_o);
                    check_block("best_pred_o", cmp_res.pred, best_pred_o);
                    checked++;
                end
                last_mode  = best_mode_o;
                last_score = best_score_o;
                last_pred  = best_pred_o;
            end else begin
                check_mode("best_mode_o hold", last_mode, best_mode_o);
                check_score("best_score_o hold", last_score, best_score_o);
                check_block("best_pred_o hold", last_pred, best_pred_o);
            end
        end
    end

    always @(negedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Error: timeout after %0d cycles, %0d results pending",
                     cycles, exp_q.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        pix_block_t src;
        row_t       nb_top;
        row_t       nb_left;
        pix_t       tl;
        lambda_t    lam;
        clk = 1'b0;
        rst_n = 1'b0;
        start_i = 1'b0;
        src_i = '0;
        top_left_i = '0;
        top_i = '0;
        left_i = '0;
        lambda_i = '0;
        cycles = 0;
        free_at = 0;
        checked = 0;
        mismatches = 0;
        protocol_errs = 0;
        seed = 64709;
        last_mode = MODE_DC;
        last_score = '0;
        last_pred = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (done_o !== 1'b0) begin
            $display("Error: done_o high after reset before any start");
            protocol_errs++;
        end
        check_mode("best_mode_o reset", MODE_DC, best_mode_o);
        check_score("best_score_o reset", '0, best_score_o);
        check_block("best_pred_o reset", '0, best_pred_o);

        // Flat block, DC wins on cost alone
        drive_block({16{8'd100}}, 8'd100, {4{8'd100}}, {4{8'd100}}, 16'd1000);
        expect_best(MODE_DC);
        check_score("best_score_o flat", score_t'(1000 * 40), best_score_o);

        // Exact VE, HE and clipped TM blocks
        drive_block({4{32'hC878_3C0A}}, 8'd0, 32'hC878_3C0A, 32'hDC8C_5A32, 16'd10);
        expect_best(MODE_VE);
        src = {{4{8'hC8}}, {4{8'h78}}, {4{8'h3C}}, {4{8'h0A}}};
        drive_block(src, 8'd0, 32'hDC8C_5A32, 32'hC878_3C0A, 16'd10);
        expect_best(MODE_HE);
        src = predict_block(MODE_TM, 8'd60, 32'hFAB4_6414, 32'hF0AA_5A0A);
        drive_block(src, 8'd60, 32'hFAB4_6414, 32'hF0AA_5A0A, 16'd10);
        expect_best(MODE_TM);

        // Symmetric block, VE and HE tie at lambda 0
        for (int i = 0; i < 16; i++)
            src.pix[i] = (i % 4 == 3 || i / 4 == 3) ? 8'd240 : 8'd0;
        drive_block(src, 8'd240, 32'hF000_0000, 32'hF000_0000, 16'd0);
        expect_best(MODE_VE);

        // Starts at E2 and E4 land in the busy window
        drive_block(src, 8'd7, 32'h1234_5678, 32'h9ABC_DEF0, 16'd300);
        drive_block(~src, 8'd9, 32'h9ABC_DEF0, 32'h1234_5678, 16'd5);
        drive_block(src, 8'd1, 32'h0, 32'h0, 16'd0);
        wait_idle();

        for (int n = 0; n < NUM_RESULTS - 6; n++) begin
            tl = pix_t'($random(seed));
            nb_top = row_t'($random(seed));
            nb_left = row_t'($random(seed));
            for (int i = 0; i < 16; i++)
                src.pix[i] = pix_t'($random(seed));
            // Half the blocks sit near one predictor
            if ($random(seed) & 1)
                src = predict_block(mode_t'($random(seed) & 3), tl, nb_top, nb_left)
                      ^ (src & {16{8'h07}});
            lam = ($random(seed) & 1) ? lambda_t'($random(seed)) : lambda_t'($random(seed) & 63);
            drive_block(src, tl, nb_top, nb_left, lam);
            if (($random(seed) & 3) == 0)
                repeat (3) @(negedge clk);
            else
                wait_idle();
        end

        wait_idle();
        repeat (10) @(negedge clk);
        if (checked != NUM_RESULTS) begin
            $display("Error: %0d results seen, %0d expected", checked, NUM_RESULTS);
            protocol_errs++;
        end
        $display("Results checked %0d, mismatches %0d, protocol errors %0d",
                 checked, mismatches, protocol_errs);
        if (mismatches == 0 && protocol_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/intra4_top.sv */
/*
 * Intra 4x4 luma mode picker
 * Predict, score and select pipeline over DC, TM, VE and HE
 */

`default_nettype none

module intra4_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start_i,
    input  wire intra4_pkg::pix_block_t src_i,
    input  wire intra4_pkg::pix_t       top_left_i,
    input  wire intra4_pkg::row_t       top_i,
    input  wire intra4_pkg::row_t       left_i,
    input  wire intra4_pkg::lambda_t    lambda_i,
    output logic                        done_o,
    output intra4_pkg::mode_t           best_mode_o,
    output intra4_pkg::score_t          best_score_o,
    output intra4_pkg::pix_block_t      best_pred_o
);

    import intra4_pkg::*;

    // Predict to score
    logic       pred_valid;
    mode_t      pred_mode;
    pix_block_t pred_block;
    pix_block_t src_block;
    lambda_t    lambda_q;

    // Score to select
    logic       score_valid;
    mode_t      score_mode;
    score_t     score;
    pix_block_t score_pred;

    intra4_predict intra4_predict_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .src_i        (src_i),
        .top_left_i   (top_left_i),
        .top_i        (top_i),
        .left_i       (left_i),
        .lambda_i     (lambda_i),
        .lambda_o     (lambda_q),
        .pred_valid_o (pred_valid),
        .pred_mode_o  (pred_mode),
        .pred_block_o (pred_block),
        .src_block_o  (src_block)
    );

    intra4_sse intra4_sse_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pred_valid_i  (pred_valid),
        .pred_mode_i   (pred_mode),
        .pred_block_i  (pred_block),
        .src_block_i   (src_block),
        .lambda_i      (lambda_q),
        .score_valid_o (score_valid),
        .score_mode_o  (score_mode),
        .score_o       (score),
        .score_pred_o  (score_pred)
    );

    intra4_best intra4_best_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .score_valid_i (score_valid),
        .score_mode_i  (score_mode),
        .score_i       (score),
        .score_pred_i  (score_pred),
        .done_o        (done_o),
        .best_mode_o   (best_mode_o),
        .best_score_o  (best_score_o),
        .best_pred_o   (best_pred_o)
    );

endmodule

`default_nettype wire

/* design/intra4_best.sv */
/*
 * Intra 4x4 best mode selection
 * Tracks the lowest score per block and reports it with a done pulse
 */

`default_nettype none

module intra4_best (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   score_valid_i,
    input  wire intra4_pkg::mode_t      score_mode_i,
    input  wire intra4_pkg::score_t     score_i,
    input  wire intra4_pkg::pix_block_t score_pred_i,
    output logic                        done_o,
    output intra4_pkg::mode_t           best_mode_o,
    output intra4_pkg::score_t          best_score_o,
    output intra4_pkg::pix_block_t      best_pred_o
);

    import intra4_pkg::*;

    logic       take;
    mode_t      best_mode_q;
    score_t     best_score_q;
    pix_block_t best_pred_q;
    mode_t      sel_mode;
    score_t     sel_score;
    pix_block_t sel_pred;

    // DC opens a block, later modes need a strictly lower score
    assign take = score_valid_i && (score_mode_i == MODE_DC || score_i < best_score_q);

    assign sel_mode  = take ? score_mode_i : best_mode_q;
    assign sel_score = take ? score_i      : best_score_q;
    assign sel_pred  = take ? score_pred_i : best_pred_q;

    always_ff @(posedge clk) begin
        if (take) begin
            best_mode_q  <= score_mode_i;
            best_score_q <= score_i;
            best_pred_q  <= score_pred_i;
        end
    end

    // Result registers, loaded when HE closes the block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o       <= 1'b0;
            best_mode_o  <= MODE_DC;
            best_score_o <= '0;
            best_pred_o  <= '0;
        end else begin
            done_o <= score_valid_i && score_mode_i == MODE_HE;
            if (score_valid_i && score_mode_i == MODE_HE) begin
                best_mode_o  <= sel_mode;
                best_score_o <= sel_score;
                best_pred_o  <= sel_pred;
            end
        end
    end

endmodule

`default_nettype wire

/* design/intra4_sse.sv */
/*
 * Intra 4x4 score stage
 * SSE against the source plus lambda-weighted fixed mode cost
 */

`default_nettype none

`include "intra4_defs.svh"

module intra4_sse (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   pred_valid_i,
    input  wire intra4_pkg::mode_t      pred_mode_i,
    input  wire intra4_pkg::pix_block_t pred_block_i,
    input  wire intra4_pkg::pix_block_t src_block_i,
    input  wire intra4_pkg::lambda_t    lambda_i,
    output logic                        score_valid_o,
    output intra4_pkg::mode_t           score_mode_o,
    output intra4_pkg::score_t          score_o,
    output intra4_pkg::pix_block_t      score_pred_o
);

    import intra4_pkg::*;

    sse_t        sse_d;
    logic [15:0] cost;
    score_t      score_d;

    function automatic logic [15:0] sq_diff(input pix_t a, input pix_t b);
        pix_t d;
        d = (a > b) ? a - b : b - a;
        return d * d;
    endfunction

    always_comb begin
        sse_d = '0;
        for (int i = 0; i < 16; i++)
            sse_d = sse_d + sse_t'(sq_diff(src_block_i.pix[i], pred_block_i.pix[i]));
    end

    always_comb begin
        case (pred_mode_i)
            MODE_DC: cost = `INTRA4_COST_DC;
            MODE_TM: cost = `INTRA4_COST_TM;
            MODE_VE: cost = `INTRA4_COST_VE;
            default: cost = `INTRA4_COST_HE;
        endcase
    end

    // 256*SSE keeps distortion and rate on the same scale
    assign score_d = {sse_d, 8'h00} + score_t'(lambda_i) * score_t'(cost);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            score_valid_o <= 1'b0;
        else
            score_valid_o <= pred_valid_i;
    end

    always_ff @(posedge clk) begin
        score_mode_o <= pred_mode_i;
        score_o      <= score_d;
        score_pred_o <= pred_block_i;
    end

endmodule

`default_nettype wire

/* design/intra4_predict.sv */
/*
 * Intra 4x4 predictor stage
 * Latches block, neighbours and lambda on start and issues the
 * DC, TM, VE and HE predictions on four consecutive cycles
 */

`default_nettype none

`include "intra4_defs.svh"

module intra4_predict (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start_i,
    input  wire intra4_pkg::pix_block_t src_i,
    input  wire intra4_pkg::pix_t       top_left_i,
    input  wire intra4_pkg::row_t       top_i,
    input  wire intra4_pkg::row_t       left_i,
    input  wire intra4_pkg::lambda_t    lambda_i,
    output intra4_pkg::lambda_t         lambda_o,
    output logic                        pred_valid_o,
    output intra4_pkg::mode_t           pred_mode_o,
    output intra4_pkg::pix_block_t      pred_block_o,
    output intra4_pkg::pix_block_t      src_block_o
);

    import intra4_pkg::*;

    logic       busy;
    logic       accept;
    mode_t      mode_q;
    pix_block_t src_q;
    pix_t       top_left_q;
    row_t       top_q;
    row_t       left_q;
    logic [10:0] dc_sum;
    pix_t       dc_pix;
    pix_block_t pred_d;

    // TrueMotion pixel, clipped to the pixel range
    function automatic pix_t tm_pix(input pix_t t, input pix_t l, input pix_t tl);
        logic signed [9:0] v;
        v = $signed({2'b00, t}) + $signed({2'b00, l}) - $signed({2'b00, tl});
        if (v < 0)
            return '0;
        else if (v > 10'sd255)
            return '1;
        else
            return v[7:0];
    endfunction

    assign accept = start_i && !busy;

    // ------------------------------------------------------------------------
    // Mode sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            mode_q <= MODE_DC;
        end else if (accept) begin
            busy   <= 1'b1;
            mode_q <= MODE_DC;
        end else if (busy) begin
            mode_q <= mode_t'(mode_q + 2'd1);
            if (mode_q == mode_t'(`INTRA4_NUM_MODES - 1))
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src_q      <= src_i;
            top_left_q <= top_left_i;
            top_q      <= top_i;
            left_q     <= left_i;
            lambda_o   <= lambda_i;
        end
    end

    // ------------------------------------------------------------------------
    // Prediction build
    // ------------------------------------------------------------------------
    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++)
            dc_sum = dc_sum + 11'(top_q[i]) + 11'(left_q[i]);
        dc_pix = dc_sum[10:3];

        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                case (mode_q)
                    MODE_DC: pred_d.row[y][x] = dc_pix;
                    MODE_TM: pred_d.row[y][x] = tm_pix(top_q[x], left_q[y], top_left_q);
                    MODE_VE: pred_d.row[y][x] = top_q[x];
                    default: pred_d.row[y][x] = left_q[y];
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pred_valid_o <= 1'b0;
        else
            pred_valid_o <= busy;
    end

    always_ff @(posedge clk) begin
        pred_mode_o  <= mode_q;
        pred_block_o <= pred_d;
        src_block_o  <= src_q;
    end

endmodule

`default_nettype wire

/* design/intra4_pkg.sv */
/*
 * 4x4 intra mode picker types
 * Pixel, row and block views, mode codes and score widths
 */

`default_nettype none

`include "intra4_defs.svh"

package intra4_pkg;

    typedef logic [`INTRA4_PIX_W-1:0] pix_t;

    // Pixel 0 sits in the low byte
    typedef pix_t [3:0] row_t;

    // Block index is y*4+x, row 0 in the low bits
    typedef union packed {
        pix_t [15:0] pix;
        row_t [3:0]  row;
    } pix_block_t;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } mode_t;

    typedef logic [23:0]                  sse_t;
    typedef logic [`INTRA4_SCORE_W-1:0]   score_t;
    typedef logic [`INTRA4_LAMBDA_W-1:0]  lambda_t;

endpackage

`default_nettype wire

/* design/intra4_defs.svh */
/*
 * 4x4 intra mode picker constants
 * Mode count, datapath widths and the fixed rate cost of each mode
 */

`ifndef INTRA4_DEFS_SVH
`define INTRA4_DEFS_SVH

// Evaluated modes: DC, TM, VE, HE
`define INTRA4_NUM_MODES    4

// Datapath widths
`define INTRA4_PIX_W        8
`define INTRA4_LAMBDA_W     16
`define INTRA4_SCORE_W      32

// Fixed mode costs, scaled by lambda in the score
`define INTRA4_COST_DC      16'd40
`define INTRA4_COST_TM      16'd1151
`define INTRA4_COST_VE      16'd1723
`define INTRA4_COST_HE      16'd1874

`endif
